// ==== list.f ====
+incdir+logic
logic/blender_pkg.sv
logic/pixel_relay.sv
logic/overlay_join.sv
logic/alpha_mixer.sv
logic/blender_top.sv
verif/blend_checker.sv
verif/tb_blender_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_blender_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/tb_blender_top.sv ====
`timescale 1ns/10ps
`include "blender_defs.svh"

module tb_blender_top;

	localparam int FRAME_PIX = 80;   // 10 x 8
	localparam int WIN_PIX   = 12;
	localparam int FRAMES    = 4;
	localparam int OVL_TOTAL = WIN_PIX * (FRAMES - 1);
	localparam int LIMIT     = 4000;

	logic                        clk = 1'b0;
	logic                        resetn;
	logic                        s1_enable;
	logic                        s0_valid;
	blender_pkg::pixel_t         s0_data;
	logic                        s0_sof;
	logic                        s0_need;
	logic                        s0_last;
	logic                        s0_ready;
	logic                        s1_valid;
	blender_pkg::pixel_t         s1_data;
	logic [`BLD_ALPHA_WIDTH-1:0] s1_alpha;
	logic                        s1_sof;
	logic                        s1_last;
	logic                        s1_ready;
	logic                        m_valid;
	blender_pkg::pixel_t         m_data;
	logic                        m_sof;
	logic                        m_last;
	logic                        m_ready;

	integer                      seed;
	logic [`BLD_ALPHA_WIDTH-1:0] alpha_tab [OVL_TOTAL];
	int                          base_idx = 0;
	int                          base_end = 0;
	int                          ovl_idx = 0;
	int                          ovl_end = 0;
	logic                        s0_took = 1'b0;
	logic                        s1_took = 1'b0;
	logic                        in_reset_d = 1'b0;
	int                          cycles = 0;
	int                          reset_errs = 0;
	int                          end_errs = 0;

	always #4 clk = ~clk;

	blender_top uut (.*);

	blend_checker u_chk (.*);

	always @(posedge clk) begin
		s0_took    <= s0_valid && s0_ready;
		s1_took    <= s1_valid && s1_ready;
		in_reset_d <= !resetn;
		cycles     <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout after %0d cycles with beats still outstanding", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) in_reset_d |-> !m_valid && !s0_ready && !s1_ready)
		else begin
			$display("valid or ready output high during or right after reset");
			reset_errs++;
		end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic load_base(input int i);
		int f;
		int p;
		int row;
		int col;
		f   = i / FRAME_PIX;
		p   = i % FRAME_PIX;
		row = p / 10;
		col = p % 10;
		s0_data[0] = 8'(col * 25 + f);
		s0_data[1] = 8'(row * 31 + f * 7);
		s0_data[2] = 8'((row * 10 + col) * 3 ^ (f * 64));
		s0_sof     = p == 0;
		s0_last    = col == 9;   // line end
		s0_need    = row >= 2 && row <= 4 && col >= 3 && col <= 6;
	endtask

	task automatic load_ovl(input int j);
		int q;
		q = j % WIN_PIX;
		s1_data[0] = 8'(j * 37 + 5);
		s1_data[1] = 8'(250 - j * 3);
		s1_data[2] = 8'((j * 13) ^ 8'h5a);
		s1_alpha   = (j < OVL_TOTAL) ? alpha_tab[j] : 8'h00;
		s1_sof     = q == 0;
		s1_last    = q % 4 == 3;
	endtask

	task automatic drive_step();
		if (s0_took)
			base_idx++;
		if (!s0_valid || s0_took) begin
			s0_valid = (base_idx < base_end) && (($random(seed) & 3) != 0);
			load_base(base_idx);
		end
		if (s1_took)
			ovl_idx++;
		if (!s1_valid || s1_took) begin
			s1_valid = (ovl_idx < ovl_end) && (($random(seed) & 3) != 0);
			load_ovl(ovl_idx);
		end
		m_ready = ($random(seed) & 3) != 0;
	endtask

	task automatic run_until_drained();
		logic done;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			drive_step();
			done = base_idx >= base_end && !s0_valid && u_chk.exp_left == 0 &&
				(!s1_enable || (ovl_idx >= ovl_end && !s1_valid));   // overlay parked while off
		end
	endtask

	initial begin
		int errs;
		seed      = 53450;
		resetn    = 1'b0;
		s1_enable = 1'b0;
		s0_valid  = 1'b0;
		s1_valid  = 1'b0;
		m_ready   = 1'b0;
		for (int j = 0; j < OVL_TOTAL; j++) begin
			case (j % WIN_PIX)
				0:       alpha_tab[j] = 8'h00;
				5, 11:   alpha_tab[j] = 8'hff;
				default: alpha_tab[j] = 8'($random(seed));
			endcase
		end
		load_base(0);
		load_ovl(0);
		repeat (8) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;

		base_end = FRAME_PIX;   // frame 1 passes straight through
		ovl_end  = OVL_TOTAL;   // overlay offered early and held back
		run_until_drained();

		s1_enable = 1'b1;
		base_end  = FRAMES * FRAME_PIX;
		run_until_drained();
		repeat (4) @(negedge clk);

		assert (!uut.ovl_valid)
			else begin
				$display("overlay beats were left unconsumed");
				end_errs++;
			end

		errs = u_chk.data_errs + u_chk.sof_errs + u_chk.last_errs + u_chk.order_errs +
			u_chk.stall_errs + u_chk.s1_errs + reset_errs + end_errs;
		$display("errors: data %0d sof %0d last %0d order %0d stall %0d s1 %0d reset %0d end %0d",
			u_chk.data_errs, u_chk.sof_errs, u_chk.last_errs, u_chk.order_errs,
			u_chk.stall_errs, u_chk.s1_errs, reset_errs, end_errs);
		if (errs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== verif/blend_checker.sv ====
`timescale 1ns/10ps
`include "blender_defs.svh"

module blend_checker (
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        s1_enable,

	input  logic                        s0_valid,
	input  logic                        s0_ready,
	input  blender_pkg::pixel_t         s0_data,
	input  logic                        s0_sof,
	input  logic                        s0_need,
	input  logic                        s0_last,

	input  logic                        s1_valid,
	input  logic                        s1_ready,
	input  blender_pkg::pixel_t         s1_data,
	input  logic [`BLD_ALPHA_WIDTH-1:0] s1_alpha,

	input  logic                        m_valid,
	input  logic                        m_ready,
	input  blender_pkg::pixel_t         m_data,
	input  logic                        m_sof,
	input  logic                        m_last
);

	blender_pkg::base_beat_t base_q[$];
	blender_pkg::ovl_beat_t  ovl_q[$];
	blender_pkg::out_beat_t  exp_q[$];

	blender_pkg::out_beat_t  exp_head;
	logic                    exp_avail = 1'b0;
	int                      exp_left = 0;   // accepted base beats not yet seen at the output
	int                      ovl_left = 0;

	int data_errs = 0;
	int sof_errs = 0;
	int last_errs = 0;
	int order_errs = 0;
	int stall_errs = 0;
	int s1_errs = 0;

	// e = alpha + msb, out = (s1 * e + s0 * (256 - e)) >> 8
	function automatic blender_pkg::pixel_t blend(blender_pkg::pixel_t base,
			blender_pkg::pixel_t ovl, logic [`BLD_ALPHA_WIDTH-1:0] alpha);
		int e;
		int v;
		int c;
		blender_pkg::pixel_t r;
		e = int'(alpha) + (alpha >= 8'd128 ? 1 : 0);
		for (c = 0; c < `BLD_CHN_NUM; c++) begin
			v = (int'(ovl[c]) * e + int'(base[c]) * (256 - e)) >> 8;
			r[c] = v[7:0];
		end
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		blender_pkg::base_beat_t b;
		blender_pkg::ovl_beat_t  o;
		blender_pkg::out_beat_t  e;
		if (!resetn) begin
			base_q.delete();
			ovl_q.delete();
			exp_q.delete();
		end else begin
			if (s0_valid && s0_ready)
				base_q.push_back('{sof: s0_sof, need: s0_need, last: s0_last, pixel: s0_data});
			if (s1_valid && s1_ready)
				ovl_q.push_back('{sof: 1'b0, last: 1'b0, pix: '{alpha: s1_alpha, pixel: s1_data}});
			if (m_valid && m_ready && exp_avail)
				void'(exp_q.pop_front());
			while (base_q.size() > 0) begin
				b = base_q[0];
				if (b.need && s1_enable) begin
					if (ovl_q.size() == 0)
						break;   // waits for its overlay beat
					o = ovl_q.pop_front();
					e.pixel = blend(b.pixel, o.pix.pixel, o.pix.alpha);
				end else begin
					e.pixel = b.pixel;
				end
				e.sof  = b.sof;
				e.last = b.last;
				exp_q.push_back(e);
				void'(base_q.pop_front());
			end
		end
		exp_avail <= exp_q.size() > 0;
		if (exp_q.size() > 0)
			exp_head <= exp_q[0];
		exp_left <= base_q.size() + exp_q.size();
		ovl_left <= ovl_q.size();
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_data: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && m_ready && exp_avail |-> m_data == exp_head.pixel)
		else begin
			$display("[FAIL] m_data got %h expected %h", $sampled(m_data),
				$sampled(exp_head.pixel));
			data_errs++;
		end

	a_sof: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && m_ready && exp_avail |-> m_sof == exp_head.sof)
		else begin
			$display("[FAIL] m_sof got %h expected %h", $sampled(m_sof), $sampled(exp_head.sof));
			sof_errs++;
		end

	a_last: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && m_ready && exp_avail |-> m_last == exp_head.last)
		else begin
			$display("[FAIL] m_last got %h expected %h", $sampled(m_last),
				$sampled(exp_head.last));
			last_errs++;
		end

	a_no_extra: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && m_ready |-> exp_avail)
		else begin
			$display("output beat arrived with no expected beat left");
			order_errs++;
		end

	a_stall: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_sof) && $stable(m_last))
		else begin
			$display("output dropped or changed while m_ready was low");
			stall_errs++;
		end

	// with blending off, overlay beats only fill the input relay's two registers
	a_s1_idle: assert property (@(posedge clk) disable iff (!resetn)
		!s1_enable && s1_valid && s1_ready |-> ovl_left < 2)
		else begin
			$display("overlay beats drained while blending was off");
			s1_errs++;
		end

endmodule

// ==== logic/blender_top.sv ====
`timescale 1ns/10ps
`include "blender_defs.svh"

module blender_top (
	input  logic                        clk,
	input  logic                        resetn,

	input  logic                        s1_enable,

	// base stream
	input  logic                        s0_valid,
	input  blender_pkg::pixel_t         s0_data,
	input  logic                        s0_sof,
	input  logic                        s0_need,
	input  logic                        s0_last,
	output logic                        s0_ready,

	// overlay stream
	input  logic                        s1_valid,
	input  blender_pkg::pixel_t         s1_data,
	input  logic [`BLD_ALPHA_WIDTH-1:0] s1_alpha,
	input  logic                        s1_sof,
	input  logic                        s1_last,
	output logic                        s1_ready,

	// blended output
	output logic                        m_valid,
	output blender_pkg::pixel_t         m_data,
	output logic                        m_sof,
	output logic                        m_last,
	input  logic                        m_ready
);

	blender_pkg::base_beat_t s0_beat;
	blender_pkg::ovl_beat_t  s1_beat;

	logic                    base_valid;
	logic                    base_ready;
	blender_pkg::base_beat_t base_beat;

	logic                    ovl_valid;
	logic                    ovl_ready;
	blender_pkg::ovl_beat_t  ovl_beat;

	logic                    mix_valid;
	logic                    mix_ready;
	blender_pkg::mix_beat_t  mix_beat;

	logic                    blend_valid;
	logic                    blend_ready;
	blender_pkg::out_beat_t  blend_beat;
	blender_pkg::out_beat_t  m_beat;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// packing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign s0_beat = '{sof: s0_sof, need: s0_need, last: s0_last, pixel: s0_data};
	assign s1_beat = '{sof: s1_sof, last: s1_last, pix: '{alpha: s1_alpha, pixel: s1_data}};

	assign m_data = m_beat.pixel;
	assign m_sof  = m_beat.sof;
	assign m_last = m_beat.last;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	pixel_relay #(.payload_t(blender_pkg::base_beat_t)) u_s0_relay (
		.clk(clk), .resetn(resetn),
		.in_valid(s0_valid), .in_data(s0_beat), .in_ready(s0_ready),
		.out_valid(base_valid), .out_data(base_beat), .out_ready(base_ready)
	);

	pixel_relay #(.payload_t(blender_pkg::ovl_beat_t)) u_s1_relay (
		.clk(clk), .resetn(resetn),
		.in_valid(s1_valid), .in_data(s1_beat), .in_ready(s1_ready),
		.out_valid(ovl_valid), .out_data(ovl_beat), .out_ready(ovl_ready)
	);

	overlay_join u_join (
		.clk(clk), .resetn(resetn), .s1_enable(s1_enable),
		.base_valid(base_valid), .base_data(base_beat), .base_ready(base_ready),
		.ovl_valid(ovl_valid), .ovl_data(ovl_beat), .ovl_ready(ovl_ready),
		.mix_valid(mix_valid), .mix_data(mix_beat), .mix_ready(mix_ready)
	);

	alpha_mixer u_mixer (
		.clk(clk), .resetn(resetn),
		.in_valid(mix_valid), .in_data(mix_beat), .in_ready(mix_ready),
		.out_valid(blend_valid), .out_data(blend_beat), .out_ready(blend_ready)
	);

	pixel_relay #(.payload_t(blender_pkg::out_beat_t)) u_out_relay (
		.clk(clk), .resetn(resetn),
		.in_valid(blend_valid), .in_data(blend_beat), .in_ready(blend_ready),
		.out_valid(m_valid), .out_data(m_beat), .out_ready(m_ready)
	);

endmodule

// ==== logic/alpha_mixer.sv ====
`timescale 1ns/10ps
`include "blender_defs.svh"

module alpha_mixer (
	input  logic                   clk,
	input  logic                   resetn,

	input  logic                   in_valid,
	input  blender_pkg::mix_beat_t in_data,
	output logic                   in_ready,

	output logic                   out_valid,
	output blender_pkg::out_beat_t out_data,
	input  logic                   out_ready
);

	localparam int CW = `BLD_CHN_WIDTH;
	localparam int CN = `BLD_CHN_NUM;
	localparam int AW = `BLD_ALPHA_WIDTH;
	localparam int EW = AW + 1;    // effective alpha runs 0..256
	localparam int PW = CW + EW;   // product and sum

	logic [EW-1:0]         e_ovl;
	logic [EW-1:0]         e_base;
	logic [CN-1:0][PW-1:0] prod_ovl;
	logic [CN-1:0][PW-1:0] prod_base;

	logic                  st1_valid;
	logic                  st1_en;
	logic                  st1_sof;
	logic                  st1_last;
	logic                  st1_mix;
	blender_pkg::pixel_t   st1_base;
	logic [CN-1:0][PW-1:0] st1_p_ovl;
	logic [CN-1:0][PW-1:0] st1_p_base;

	logic [CN-1:0][PW-1:0] sum;
	blender_pkg::pixel_t   mixed;

	logic                  st2_valid;
	logic                  st2_en;
	blender_pkg::out_beat_t st2_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stall control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign st2_en   = !st2_valid || out_ready;
	assign st1_en   = !st1_valid || st2_en;
	assign in_ready = st1_en;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			st1_valid <= 1'b0;
			st2_valid <= 1'b0;
		end else begin
			if (st1_en)
				st1_valid <= in_valid;
			if (st2_en)
				st2_valid <= st1_valid;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1: weights and products
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign e_ovl  = {1'b0, in_data.alpha} + EW'(in_data.alpha[AW-1]);   // 255 maps to 256
	assign e_base = EW'(1 << AW) - e_ovl;

	for (genvar c = 0; c < CN; c++) begin : g_prod
		assign prod_ovl[c]  = PW'(in_data.ovl[c]) * PW'(e_ovl);
		assign prod_base[c] = PW'(in_data.base[c]) * PW'(e_base);
	end

	always_ff @(posedge clk) begin
		if (st1_en) begin
			st1_sof    <= in_data.sof;
			st1_last   <= in_data.last;
			st1_mix    <= in_data.mix;
			st1_base   <= in_data.base;
			st1_p_ovl  <= prod_ovl;
			st1_p_base <= prod_base;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2: sum and shift
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar c = 0; c < CN; c++) begin : g_sum
		assign sum[c]   = st1_p_ovl[c] + st1_p_base[c];   // at most 255 * 256
		assign mixed[c] = sum[c][AW +: CW];
	end

	always_ff @(posedge clk) begin
		if (st2_en) begin
			st2_data.sof   <= st1_sof;
			st2_data.last  <= st1_last;
			st2_data.pixel <= st1_mix ? mixed : st1_base;
		end
	end

	assign out_valid = st2_valid;
	assign out_data  = st2_data;

	// held output stays put until taken
	a_stall_stable: assert property (@(posedge clk) disable iff (!resetn)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// ==== logic/overlay_join.sv ====
`timescale 1ns/10ps

module overlay_join (
	input  logic                    clk,
	input  logic                    resetn,

	input  logic                    s1_enable,

	input  logic                    base_valid,
	input  blender_pkg::base_beat_t base_data,
	output logic                    base_ready,

	input  logic                    ovl_valid,
	input  blender_pkg::ovl_beat_t  ovl_data,
	output logic                    ovl_ready,

	output logic                    mix_valid,
	output blender_pkg::mix_beat_t  mix_data,
	input  logic                    mix_ready
);

	logic pair_need;   // base beat waits for an overlay beat
	logic ovl_ok;      // overlay side does not block

	assign pair_need = base_data.need && s1_enable;
	assign ovl_ok    = !pair_need || ovl_valid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign mix_valid  = base_valid && ovl_ok;
	assign base_ready = mix_ready && ovl_ok;
	assign ovl_ready  = mix_ready && base_valid && pair_need;   // consumed with its base beat

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// mix beat
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		mix_data.sof  = base_data.sof;
		mix_data.last = base_data.last;
		mix_data.mix  = pair_need;
		mix_data.base = base_data.pixel;
		if (pair_need) begin
			mix_data.alpha = ovl_data.pix.alpha;
			mix_data.ovl   = ovl_data.pix.pixel;
		end else begin
			mix_data.alpha = '0;   // keeps payload stable while s1 moves
			mix_data.ovl   = '0;
		end
	end

	// overlay beats leave only together with a base beat that asked for them
	a_ovl_paired: assert property (@(posedge clk) disable iff (!resetn)
		ovl_valid && ovl_ready |-> base_valid && base_ready && pair_need);

endmodule

// ==== logic/pixel_relay.sv ====
`timescale 1ns/10ps

module pixel_relay #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     resetn,

	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,

	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	logic     in_fire;
	logic     out_free;   // main register may take a new beat
	logic     skid_valid;
	logic     skid_next;
	payload_t skid_data;

	assign in_fire  = in_valid && in_ready;
	assign out_free = !out_valid || out_ready;

	always_comb begin
		if (skid_valid)
			skid_next = !out_free;   // drains once output moves
		else
			skid_next = in_fire && !out_free;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!resetn) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
			in_ready   <= 1'b0;
		end else begin
			out_valid  <= !out_free || skid_valid || in_fire;
			skid_valid <= skid_next;
			in_ready   <= !skid_next;   // registered ready
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// payload
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (in_ready && !out_free)
			skid_data <= in_data;   // skid is empty while ready
		if (out_free) begin
			if (skid_valid)
				out_data <= skid_data;
			else
				out_data <= in_data;
		end
	end

	// stalled output must not move
	a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

	// a beat in the skid register sits behind a held output and blocks the input
	a_skid_block: assert property (@(posedge clk) disable iff (!resetn)
		skid_valid |-> out_valid && !in_ready);

endmodule

// ==== logic/blender_pkg.sv ====
`include "blender_defs.svh"

package blender_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pixels
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [`BLD_CHN_NUM-1:0][`BLD_CHN_WIDTH-1:0] pixel_t;

	typedef struct packed {
		logic [`BLD_ALPHA_WIDTH-1:0] alpha;
		pixel_t                      pixel;
	} ovl_pixel_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stream beats
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic   sof;
		logic   need;   // covered by overlay window
		logic   last;
		pixel_t pixel;
	} base_beat_t;

	typedef struct packed {
		logic       sof;
		logic       last;
		ovl_pixel_t pix;
	} ovl_beat_t;

	typedef struct packed {
		logic                        sof;
		logic                        last;
		logic                        mix;   // clear means pass base through
		logic [`BLD_ALPHA_WIDTH-1:0] alpha;
		pixel_t                      base;
		pixel_t                      ovl;
	} mix_beat_t;

	typedef struct packed {
		logic   sof;
		logic   last;
		pixel_t pixel;
	} out_beat_t;

endpackage

// ==== logic/blender_defs.svh ====
`ifndef BLENDER_DEFS_SVH
`define BLENDER_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel format
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define BLD_CHN_WIDTH   8 // bits per channel
`define BLD_CHN_NUM     3 // channels per pixel

`define BLD_ALPHA_WIDTH 8 // overlay alpha

`endif
